// File: Makefile
TOP := dcache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f dcache_top.f

run: compile
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// File: dcache_top.f
src/dcache_pkg.sv
src/dcache_bus_if.sv
src/line_ram.sv
src/cpu_req_port.sv
src/cache_ctrl.sv
src/mem_port.sv
src/dcache_top.sv
testbench/dcache_chk.sv
testbench/dcache_tb.sv

// File: src/cache_ctrl.sv
// ************************************************
// cache controller: FSM, valid/dirty/tag arrays
// fence walk, line merge and word select
// ************************************************
`timescale 1ns/1ps

module cache_ctrl #(
    parameter int INDEX_W = 6
) (
    input  logic clk,
    input  logic rst,
    input  logic fence_i,
    output logic cache_idle_o,
    req_if.ctrl  req_bus,
    mem_if.ctrl  mem_bus
);
    localparam int NLINE = 2 ** INDEX_W;
    localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - INDEX_W;

    dcache_pkg::ctrl_state_t state_q;
    dcache_pkg::ctrl_state_t state_d;
    logic [INDEX_W-1:0]      cnt_q;
    logic [INDEX_W-1:0]      cnt_d;
    logic [NLINE-1:0]        valid_q;
    logic [NLINE-1:0]        dirty_q;
    logic [TAG_W-1:0]        tag_q [NLINE];
    logic                    done_q;
    logic                    hit;
    logic                    victim_dirty;
    logic                    flush_dirty;
    logic                    ram_we;
    logic [INDEX_W-1:0]      ram_addr;
    dcache_pkg::line_t       ram_wdata;
    dcache_pkg::line_t       ram_rdata;
    dcache_pkg::line_t       lane_bits;
    dcache_pkg::line_t       merged;

    assign hit          = valid_q[req_bus.index] && (tag_q[req_bus.index] == req_bus.tag);
    assign victim_dirty = valid_q[req_bus.index] && dirty_q[req_bus.index];
    assign flush_dirty  = valid_q[cnt_q] && dirty_q[cnt_q];

    always_comb begin
        state_d       = state_q;
        cnt_d         = cnt_q;
        mem_bus.start = 1'b0;
        mem_bus.write = 1'b0;
        mem_bus.addr  = {req_bus.tag, req_bus.index, {dcache_pkg::OFFSET_W{1'b0}}};
        mem_bus.wline = ram_rdata;
        case (state_q)
            dcache_pkg::IDLE: begin
                // done still high means the last read is retiring
                if (req_bus.pending && !done_q) begin
                    state_d = dcache_pkg::COMPARE;
                end else if (!req_bus.pending && fence_i) begin
                    state_d = dcache_pkg::FLUSH;
                    cnt_d   = '0;
                end
            end
            dcache_pkg::COMPARE: begin
                if (hit) begin
                    state_d = dcache_pkg::HIT_ACCESS;
                end else begin
                    mem_bus.start = 1'b1;
                    if (victim_dirty) begin
                        mem_bus.write = 1'b1;
                        mem_bus.addr  = {tag_q[req_bus.index], req_bus.index,
                                         {dcache_pkg::OFFSET_W{1'b0}}};
                        state_d       = dcache_pkg::WRITE_BACK;
                    end else begin
                        state_d = dcache_pkg::ALLOCATE;
                    end
                end
            end
            dcache_pkg::HIT_ACCESS: begin
                state_d = req_bus.rw ? dcache_pkg::WRITE_LINE : dcache_pkg::IDLE;
            end
            dcache_pkg::WRITE_LINE: state_d = dcache_pkg::IDLE;
            dcache_pkg::WRITE_BACK: begin
                if (mem_bus.finish) begin
                    mem_bus.start = 1'b1;   // refill right behind the victim
                    state_d       = dcache_pkg::ALLOCATE;
                end
            end
            dcache_pkg::ALLOCATE: begin
                if (mem_bus.finish) begin
                    state_d = dcache_pkg::COMPARE;
                end
            end
            dcache_pkg::FLUSH: begin
                if (flush_dirty) begin
                    mem_bus.start = 1'b1;
                    mem_bus.write = 1'b1;
                    mem_bus.addr  = {tag_q[cnt_q], cnt_q, {dcache_pkg::OFFSET_W{1'b0}}};
                    state_d       = dcache_pkg::FLUSH_NEXT;
                end else if (&cnt_q) begin
                    state_d = dcache_pkg::IDLE;
                end else begin
                    cnt_d = cnt_q + 1'b1;
                end
            end
            dcache_pkg::FLUSH_NEXT: begin
                if (mem_bus.finish) begin
                    if (&cnt_q) begin
                        state_d = dcache_pkg::IDLE;
                    end else begin
                        cnt_d   = cnt_q + 1'b1;
                        state_d = dcache_pkg::FLUSH;
                    end
                end
            end
            default: state_d = dcache_pkg::IDLE;
        endcase
    end

    // RAM reads the next flush line one cycle ahead
    assign ram_addr  = (state_d == dcache_pkg::FLUSH) ? cnt_d : req_bus.index;
    assign ram_we    = (state_q == dcache_pkg::WRITE_LINE) ||
                       (state_q == dcache_pkg::ALLOCATE && mem_bus.finish);
    assign ram_wdata = (state_q == dcache_pkg::WRITE_LINE) ? merged : mem_bus.rline;

    always_comb begin
        for (int b = 0; b < 16; b++) begin
            lane_bits[8*b +: 8] = {8{req_bus.lanes[b]}};
        end
    end

    assign merged = ({2{req_bus.wdata}} & lane_bits) | (ram_rdata & ~lane_bits);

    line_ram #(
        .INDEX_W(INDEX_W)
    ) u_line_ram (
        .clk    (clk),
        .we_i   (ram_we),
        .addr_i (ram_addr),
        .wdata_i(ram_wdata),
        .rdata_o(ram_rdata)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= dcache_pkg::IDLE;
            cnt_q   <= '0;
            valid_q <= '0;
            dirty_q <= '0;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            done_q  <= (state_q == dcache_pkg::HIT_ACCESS);
            if (state_q == dcache_pkg::ALLOCATE && mem_bus.finish) begin
                valid_q[req_bus.index] <= 1'b1;
                dirty_q[req_bus.index] <= 1'b0;
            end
            if (state_q == dcache_pkg::WRITE_LINE) begin
                dirty_q[req_bus.index] <= 1'b1;
            end
            if (state_q == dcache_pkg::FLUSH_NEXT && mem_bus.finish) begin
                dirty_q[cnt_q] <= 1'b0;   // line is clean in memory now
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::ALLOCATE && mem_bus.finish) begin
            tag_q[req_bus.index] <= req_bus.tag;
        end
    end

    assign req_bus.done  = done_q;
    assign req_bus.rdata = req_bus.word_sel ? ram_rdata[127:64] : ram_rdata[63:0];
    assign cache_idle_o  = (state_q == dcache_pkg::IDLE);

endmodule

// File: src/cpu_req_port.sv
// ************************************************
// cpu request capture, address split
// byte lane enables, ready and read data
// ************************************************
`timescale 1ns/1ps

module cpu_req_port #(
    parameter int INDEX_W = 6
) (
    input  logic              clk,
    input  logic              rst,
    input  dcache_pkg::addr_t cpu_req_addr_i,
    input  logic              cpu_req_rw_i,
    input  logic              cpu_req_valid_i,
    input  dcache_pkg::word_t cpu_data_write_i,
    input  dcache_pkg::mask_t cpu_wmask_i,
    output dcache_pkg::word_t cpu_data_read_o,
    output logic              cpu_ready_o,
    req_if.port               req_bus
);
    localparam int TAG_LSB = dcache_pkg::OFFSET_W + INDEX_W;

    logic              pending_q;
    logic              accept;
    logic              word_sel;
    dcache_pkg::lane_t lanes;

    // no new request while one is open or its ready is still out
    assign accept   = cpu_req_valid_i && !pending_q && !cpu_ready_o;
    assign word_sel = cpu_req_addr_i[dcache_pkg::OFFSET_W-1];

    always_comb begin
        if (!cpu_req_rw_i) begin
            lanes = '0;
        end else if (word_sel) begin
            lanes = {cpu_wmask_i, 8'h00};
        end else begin
            lanes = {8'h00, cpu_wmask_i};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending_q   <= 1'b0;
            cpu_ready_o <= 1'b0;
        end else begin
            cpu_ready_o <= req_bus.done;
            if (req_bus.done) begin
                pending_q <= 1'b0;
            end else if (accept) begin
                pending_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_bus.tag      <= cpu_req_addr_i[dcache_pkg::ADDR_W-1:TAG_LSB];
            req_bus.index    <= cpu_req_addr_i[TAG_LSB-1:dcache_pkg::OFFSET_W];
            req_bus.word_sel <= word_sel;
            req_bus.rw       <= cpu_req_rw_i;
            req_bus.wdata    <= cpu_data_write_i;
            req_bus.lanes    <= lanes;
        end
        if (req_bus.done) begin
            cpu_data_read_o <= req_bus.rdata;
        end
    end

    assign req_bus.pending = pending_q;

endmodule

// File: src/dcache_bus_if.sv
// ************************************************
// req_if  captured cpu request to controller
// mem_if  controller to memory port
// ************************************************
`timescale 1ns/1ps

interface req_if #(
    parameter int INDEX_W = 6
);
    localparam int TAG_W = dcache_pkg::ADDR_W - dcache_pkg::OFFSET_W - INDEX_W;

    logic [TAG_W-1:0]   tag;
    logic [INDEX_W-1:0] index;
    logic               word_sel;   // upper half of the line
    logic               rw;
    dcache_pkg::word_t  wdata;
    dcache_pkg::lane_t  lanes;
    logic               pending;
    logic               done;
    dcache_pkg::word_t  rdata;

    modport port (output tag, index, word_sel, rw, wdata, lanes, pending, input done, rdata);
    modport ctrl (input tag, index, word_sel, rw, wdata, lanes, pending, output done, rdata);
endinterface

interface mem_if;
    logic              start;    // one-cycle pulse
    logic              write;
    dcache_pkg::addr_t addr;
    dcache_pkg::line_t wline;
    logic              finish;
    dcache_pkg::line_t rline;

    modport ctrl (output start, write, addr, wline, input finish, rline);
    modport port (input start, write, addr, wline, output finish, rline);
endinterface

// File: src/dcache_pkg.sv
// ************************************************
// data cache shared widths and typedefs
// controller state encoding
// ************************************************
package dcache_pkg;

    localparam int ADDR_W   = 32;
    localparam int OFFSET_W = 4;    // 16-byte lines
    localparam int LINE_W   = 128;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [63:0]       word_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [7:0]        mask_t;   // byte mask of one word
    typedef logic [15:0]       lane_t;   // byte enable over a line

    typedef enum logic [2:0] {
        IDLE,
        COMPARE,
        HIT_ACCESS,
        WRITE_LINE,
        WRITE_BACK,
        ALLOCATE,
        FLUSH,
        FLUSH_NEXT
    } ctrl_state_t;

endpackage

// File: src/dcache_top.sv
// ************************************************
// direct-mapped write-back data cache, top level
// ************************************************
`timescale 1ns/1ps

module dcache_top #(
    parameter int INDEX_W = 6
) (
    input  logic              clk,
    input  logic              rst,
    // cpu side
    input  dcache_pkg::addr_t cpu_req_addr_i,
    input  logic              cpu_req_rw_i,
    input  logic              cpu_req_valid_i,
    input  dcache_pkg::word_t cpu_data_write_i,
    input  dcache_pkg::mask_t cpu_wmask_i,
    output dcache_pkg::word_t cpu_data_read_o,
    output logic              cpu_ready_o,
    output logic              cache_idle_o,
    input  logic              fence_i,
    // memory side
    output dcache_pkg::addr_t rw_addr_o,
    output logic              rw_req_o,
    output logic              rw_valid_o,
    output dcache_pkg::line_t rw_w_data_o,
    input  dcache_pkg::line_t data_read_i,
    input  logic              rw_ready_i
);
    req_if #(.INDEX_W(INDEX_W)) req_bus ();
    mem_if mem_bus ();

    cpu_req_port #(
        .INDEX_W(INDEX_W)
    ) u_cpu_req_port (
        .clk             (clk),
        .rst             (rst),
        .cpu_req_addr_i  (cpu_req_addr_i),
        .cpu_req_rw_i    (cpu_req_rw_i),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_data_write_i(cpu_data_write_i),
        .cpu_wmask_i     (cpu_wmask_i),
        .cpu_data_read_o (cpu_data_read_o),
        .cpu_ready_o     (cpu_ready_o),
        .req_bus         (req_bus)
    );

    cache_ctrl #(
        .INDEX_W(INDEX_W)
    ) u_cache_ctrl (
        .clk         (clk),
        .rst         (rst),
        .fence_i     (fence_i),
        .cache_idle_o(cache_idle_o),
        .req_bus     (req_bus),
        .mem_bus     (mem_bus)
    );

    mem_port u_mem_port (
        .clk        (clk),
        .rst        (rst),
        .mem_bus    (mem_bus),
        .rw_addr_o  (rw_addr_o),
        .rw_req_o   (rw_req_o),
        .rw_valid_o (rw_valid_o),
        .rw_w_data_o(rw_w_data_o),
        .data_read_i(data_read_i),
        .rw_ready_i (rw_ready_i)
    );

endmodule

// File: src/line_ram.sv
// ************************************************
// single-port line RAM, registered read
// ************************************************
`timescale 1ns/1ps

module line_ram #(
    parameter int INDEX_W = 6
) (
    input  logic               clk,
    input  logic               we_i,
    input  logic [INDEX_W-1:0] addr_i,
    input  dcache_pkg::line_t  wdata_i,
    output dcache_pkg::line_t  rdata_o
);
    dcache_pkg::line_t mem [2**INDEX_W];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
        rdata_o <= mem[addr_i];   // old data on a write cycle
    end

endmodule

// File: src/mem_port.sv
// ************************************************
// memory bus port: registered request,
// valid held until ready, refill capture
// ************************************************
`timescale 1ns/1ps

module mem_port (
    input  logic              clk,
    input  logic              rst,
    mem_if.port               mem_bus,
    output dcache_pkg::addr_t rw_addr_o,
    output logic              rw_req_o,
    output logic              rw_valid_o,
    output dcache_pkg::line_t rw_w_data_o,
    input  dcache_pkg::line_t data_read_i,
    input  logic              rw_ready_i
);
    logic finish_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rw_valid_o <= 1'b0;
            rw_req_o   <= 1'b0;
            finish_q   <= 1'b0;
        end else begin
            finish_q <= 1'b0;
            if (mem_bus.start) begin
                rw_valid_o <= 1'b1;
                rw_req_o   <= mem_bus.write;   // high for a write
            end else if (rw_valid_o && rw_ready_i) begin
                rw_valid_o <= 1'b0;
                finish_q   <= 1'b1;
            end
        end
    end

    // payload only
    always_ff @(posedge clk) begin
        if (mem_bus.start) begin
            rw_addr_o   <= mem_bus.addr;
            rw_w_data_o <= mem_bus.wline;
        end
        if (rw_valid_o && rw_ready_i) begin
            mem_bus.rline <= data_read_i;
        end
    end

    assign mem_bus.finish = finish_q;

endmodule

// File: testbench/dcache_chk.sv
// ************************************************
// bound protocol checks on the cache ports
// ************************************************
`timescale 1ns/1ps

module dcache_chk (
    input logic              clk,
    input logic              rst,
    input logic              ready_i,
    input logic              mem_valid_i,
    input logic              mem_write_i,
    input dcache_pkg::addr_t mem_addr_i,
    input logic              mem_ready_i
);
    int fail_count = 0;

    // request held until the memory takes it
    a_mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem_valid_i && !mem_ready_i |=> mem_valid_i && $stable(mem_addr_i))
    else begin
        $error("memory request dropped or changed before ready");
        fail_count++;
    end

    a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
        ready_i |=> !ready_i)
    else begin
        $error("cpu ready longer than one cycle");
        fail_count++;
    end

    a_wb_aligned: assert property (@(posedge clk) disable iff (rst)
        mem_valid_i && mem_write_i |-> mem_addr_i[3:0] == 4'h0)
    else begin
        $error("write-back address not line aligned");
        fail_count++;
    end

    a_reset_low: assert property (@(posedge clk) rst |=> !ready_i && !mem_valid_i)
    else begin
        $error("ready or memory valid high after reset");
        fail_count++;
    end

endmodule

// File: testbench/dcache_tb.sv
// ************************************************
// data cache testbench with clock, reset, memory model
// shadow memory, directed and random accesses
// ************************************************
`timescale 1ns/1ps

module dcache_tb;

    localparam logic [31:0] SEED    = 32'h86216985;
    localparam int          TIMEOUT = 1000;

    logic              clk;
    logic              rst;
    dcache_pkg::addr_t cpu_req_addr_i;
    logic              cpu_req_rw_i;
    logic              cpu_req_valid_i;
    dcache_pkg::word_t cpu_data_write_i;
    dcache_pkg::mask_t cpu_wmask_i;
    dcache_pkg::word_t cpu_data_read_o;
    logic              cpu_ready_o;
    logic              cache_idle_o;
    logic              fence_i;
    dcache_pkg::addr_t rw_addr_o;
    logic              rw_req_o;
    logic              rw_valid_o;
    dcache_pkg::line_t rw_w_data_o;
    dcache_pkg::line_t data_read_i = '0;
    logic              rw_ready_i  = 1'b0;

    dcache_pkg::line_t shadow    [4096];   // cpu view of a 64 KB window
    dcache_pkg::line_t mem_model [4096];
    logic [27:0]       model_line  [64];   // expected cache contents
    logic              model_valid [64];
    logic              model_dirty [64];
    logic [31:0]       stim_rng;
    logic [31:0]       mem_rng;
    int                wait_left;
    int                rd_count;
    int                wr_count;
    int                errors;
    dcache_pkg::addr_t last_rd_addr;
    dcache_pkg::addr_t last_wr_addr;

    dcache_top dcache_top_i (
        .clk             (clk),
        .rst             (rst),
        .cpu_req_addr_i  (cpu_req_addr_i),
        .cpu_req_rw_i    (cpu_req_rw_i),
        .cpu_req_valid_i (cpu_req_valid_i),
        .cpu_data_write_i(cpu_data_write_i),
        .cpu_wmask_i     (cpu_wmask_i),
        .cpu_data_read_o (cpu_data_read_o),
        .cpu_ready_o     (cpu_ready_o),
        .cache_idle_o    (cache_idle_o),
        .fence_i         (fence_i),
        .rw_addr_o       (rw_addr_o),
        .rw_req_o        (rw_req_o),
        .rw_valid_o      (rw_valid_o),
        .rw_w_data_o     (rw_w_data_o),
        .data_read_i     (data_read_i),
        .rw_ready_i      (rw_ready_i)
    );

    bind dcache_top dcache_chk u_chk (
        .clk        (clk),
        .rst        (rst),
        .ready_i    (cpu_ready_o),
        .mem_valid_i(rw_valid_o),
        .mem_write_i(rw_req_o),
        .mem_addr_i (rw_addr_o),
        .mem_ready_i(rw_ready_i)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // word k holds its own byte address xor A5A50000
    function automatic dcache_pkg::line_t init_line(input dcache_pkg::addr_t a);
        return {32'h0, (a + 32'd8) ^ 32'hA5A5_0000, 32'h0, a ^ 32'hA5A5_0000};
    endfunction

    function automatic dcache_pkg::word_t merge_bytes(input dcache_pkg::word_t old_w,
                                                      input dcache_pkg::word_t new_w,
                                                      input dcache_pkg::mask_t mask);
        dcache_pkg::word_t r;
        for (int b = 0; b < 8; b++) begin
            r[8*b +: 8] = mask[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        end
        return r;
    endfunction

    task automatic check_val(input string name, input dcache_pkg::line_t exp,
                             input dcache_pkg::line_t act);
        assert (act === exp)
        else begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic expect_count(input string name, input int exp, input int act);
        assert (act == exp)
        else begin
            $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
            errors++;
        end
    endtask

    task automatic end_run();
        int total;
        total = errors + dcache_top_i.u_chk.fail_count;
        $display("errors: %0d from checks, %0d from assertions", errors,
                 dcache_top_i.u_chk.fail_count);
        if (total == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    endtask

    task automatic cpu_access(input string name, input dcache_pkg::addr_t addr,
                              input logic rw, input dcache_pkg::word_t wdata,
                              input dcache_pkg::mask_t mask);
        logic [5:0]        idx;
        logic [11:0]       la;
        logic              hit;
        logic              wb;
        int                rd0;
        int                wr0;
        int                cycles;
        dcache_pkg::word_t expected;
        idx      = addr[9:4];   // default of 64 lines
        la       = addr[15:4];
        hit      = model_valid[idx] && (model_line[idx] == addr[31:4]);
        wb       = !hit && model_valid[idx] && model_dirty[idx];
        expected = addr[3] ? shadow[la][127:64] : shadow[la][63:0];
        rd0      = rd_count;
        wr0      = wr_count;
        @(posedge clk);
        cpu_req_addr_i   <= addr;
        cpu_req_rw_i     <= rw;
        cpu_data_write_i <= wdata;
        cpu_wmask_i      <= mask;
        cpu_req_valid_i  <= 1'b1;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!cpu_ready_o && cycles < TIMEOUT);
        if (!cpu_ready_o) begin
            $display("%s: no ready from the cache within %0d cycles", name, TIMEOUT);
            errors++;
            end_run();
        end else begin
            cpu_req_valid_i <= 1'b0;
            if (!rw) begin
                check_val({name, " data"}, dcache_pkg::line_t'(expected),
                          dcache_pkg::line_t'(cpu_data_read_o));
            end
            expect_count({name, " memory reads"}, hit ? 0 : 1, rd_count - rd0);
            expect_count({name, " memory writes"}, wb ? 1 : 0, wr_count - wr0);
            if (hit) begin
                // accept is one edge in and ready is seen one edge late
                expect_count({name, " hit latency"}, 4, cycles - 2);
            end else begin
                check_val({name, " refill address"},
                          dcache_pkg::line_t'({addr[31:4], 4'h0}),
                          dcache_pkg::line_t'(last_rd_addr));
                if (wb) begin
                    check_val({name, " victim address"},
                              dcache_pkg::line_t'({model_line[idx], 4'h0}),
                              dcache_pkg::line_t'(last_wr_addr));
                end
                model_line[idx]  = addr[31:4];
                model_valid[idx] = 1'b1;
                model_dirty[idx] = 1'b0;
            end
            if (rw) begin
                if (addr[3]) begin
                    shadow[la][127:64] = merge_bytes(shadow[la][127:64], wdata, mask);
                end else begin
                    shadow[la][63:0] = merge_bytes(shadow[la][63:0], wdata, mask);
                end
                model_dirty[idx] = 1'b1;
            end
        end
    endtask

    task automatic run_fence(input string name);
        int expected;
        int wr0;
        int cycles;
        expected = 0;
        for (int i = 0; i < 64; i++) begin
            if (model_valid[i] && model_dirty[i]) begin
                expected++;
            end
        end
        wr0 = wr_count;
        @(posedge clk);
        fence_i <= 1'b1;
        @(posedge clk);
        fence_i <= 1'b0;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!cache_idle_o && cycles < TIMEOUT);
        if (!cache_idle_o) begin
            $display("%s: cache still busy after %0d cycles", name, TIMEOUT);
            errors++;
            end_run();
        end else begin
            expect_count({name, " memory writes"}, expected, wr_count - wr0);
            for (int i = 0; i < 64; i++) begin
                model_dirty[i] = 1'b0;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory answers after 0 to 5 cycles
    always @(posedge clk) begin
        rw_ready_i <= 1'b0;
        if (rst) begin
            wait_left = -1;
        end else if (rw_valid_o && !rw_ready_i) begin
            if (wait_left < 0) begin
                mem_rng   = xorshift(mem_rng);
                wait_left = mem_rng % 6;
            end
            if (wait_left == 0) begin
                if (rw_req_o) begin
                    check_val("write-back data", shadow[rw_addr_o[15:4]], rw_w_data_o);
                    mem_model[rw_addr_o[15:4]] = rw_w_data_o;
                    last_wr_addr = rw_addr_o;
                    wr_count++;
                end else begin
                    data_read_i <= mem_model[rw_addr_o[15:4]];
                    last_rd_addr = rw_addr_o;
                    rd_count++;
                end
                rw_ready_i <= 1'b1;
                wait_left = -1;
            end else begin
                wait_left--;
            end
        end
    end

    initial begin
        dcache_pkg::addr_t a;
        dcache_pkg::addr_t addr;
        dcache_pkg::word_t wd;
        logic [31:0]       r;
        errors   = 0;
        rd_count = 0;
        wr_count = 0;
        stim_rng = SEED;
        mem_rng  = SEED;
        for (int i = 0; i < 4096; i++) begin
            a            = 32'(i) << 4;
            mem_model[i] = init_line(a);
            shadow[i]    = init_line(a);
        end
        for (int i = 0; i < 64; i++) begin
            model_line[i]  = '0;
            model_valid[i] = 1'b0;
            model_dirty[i] = 1'b0;
        end
        rst              <= 1'b1;
        cpu_req_addr_i   <= '0;
        cpu_req_rw_i     <= 1'b0;
        cpu_req_valid_i  <= 1'b0;
        cpu_data_write_i <= '0;
        cpu_wmask_i      <= '0;
        fence_i          <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_val("reset ready", '0, dcache_pkg::line_t'(cpu_ready_o));
        check_val("reset mem valid", '0, dcache_pkg::line_t'(rw_valid_o));
        check_val("reset idle", dcache_pkg::line_t'(1'b1), dcache_pkg::line_t'(cache_idle_o));

        cpu_access("read miss", 32'h0000_0140, 1'b0, '0, '0);
        cpu_access("read hit", 32'h0000_0148, 1'b0, '0, '0);
        cpu_access("partial write", 32'h0000_0148, 1'b1, 64'h0123_4567_89ab_cdef, 8'hA6);
        cpu_access("merged read", 32'h0000_0148, 1'b0, '0, '0);
        // same index, other tag
        cpu_access("conflict read", 32'h0000_0540, 1'b0, '0, '0);
        cpu_access("reread after evict", 32'h0000_0148, 1'b0, '0, '0);

        for (int i = 0; i < 4; i++) begin
            wd = {32'(i), 32'hCAFE_0000};
            cpu_access("fence prep write", 32'h0000_1000 | (32'(i) << 4), 1'b1, wd, 8'h0F);
        end
        run_fence("fence");
        run_fence("second fence");

        // 4 tags over 2 indices
        for (int n = 0; n < 200; n++) begin
            stim_rng = xorshift(stim_rng);
            r        = stim_rng;
            addr     = {16'h0, 4'h2, r[1:0], 5'b00010, r[2], r[3], 3'b000};
            stim_rng = xorshift(stim_rng);
            wd       = {stim_rng, r};
            cpu_access("random", addr, r[4], wd, r[15:8]);
        end
        end_run();
    end

endmodule
